// ==== Makefile ====
# Verilator build and run for the dual-CPU subsystem

VERILATOR ?= verilator
TOP ?= cpu_subsystem_tb
FILELIST ?= cpu_subsystem.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
SIM_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= Test passed

SOURCES := $(wildcard source/*.sv) $(wildcard dv/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cpu_subsystem.f ====
source/cpu_subsystem_pkg.sv
source/master_decoder.sv
source/sub_decoder.sv
source/cpu_port.sv
source/video_bus_mux.sv
source/program_rom.sv
source/cpu_subsystem.sv
dv/cpu_subsystem_asserts.sv
dv/cpu_subsystem_tb.sv

// ==== dv/cpu_subsystem_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_subsystem_asserts (
	input wire logic clk_6m,
	input wire logic rst_n,
	input wire logic m_req,
	input wire logic m_ack,
	input wire logic s_req,
	input wire logic s_ack,
	input wire cpu_subsystem_pkg::vid_bus_t vid_bus,
	input wire logic m_grant
);

	import cpu_subsystem_pkg::*;

	int unsigned m_rise_err = 0;
	int unsigned s_rise_err = 0;
	int unsigned m_hold_err = 0;
	int unsigned s_hold_err = 0;
	int unsigned onehot_err = 0;
	int unsigned owner_err = 0;
	int unsigned fail_total;

	assign fail_total = m_rise_err + s_rise_err + m_hold_err + s_hold_err
		+ onehot_err + owner_err;

	////////////////////
	// Handshake

	// Ack only answers a live request
	assert property (@(posedge clk_6m) disable iff (!rst_n) $rose(m_ack) |-> m_req)
		else begin
			m_rise_err = m_rise_err + 1;
			$error("master ack rose without a request");
		end
	assert property (@(posedge clk_6m) disable iff (!rst_n) $rose(s_ack) |-> s_req)
		else begin
			s_rise_err = s_rise_err + 1;
			$error("sub ack rose without a request");
		end

	assert property (@(posedge clk_6m) disable iff (!rst_n) m_ack && m_req |=> m_ack)
		else begin
			m_hold_err = m_hold_err + 1;
			$error("master ack dropped while the request was still high");
		end
	assert property (@(posedge clk_6m) disable iff (!rst_n) s_ack && s_req |=> s_ack)
		else begin
			s_hold_err = s_hold_err + 1;
			$error("sub ack dropped while the request was still high");
		end

	////////////////////
	// Video bus

	assert property (@(posedge clk_6m) disable iff (!rst_n) $onehot0(vid_bus.sel))
		else begin
			onehot_err = onehot_err + 1;
			$error("video bus select has more than one bit set");
		end

	// Back-to-back bus cycles belong to alternating slots, seen through the grants
	assert property (@(posedge clk_6m) disable iff (!rst_n)
		(|vid_bus.sel) && $past(|vid_bus.sel) |=> m_grant != $past(m_grant))
		else begin
			owner_err = owner_err + 1;
			$error("video bus held by the same owner on two consecutive cycles");
		end

endmodule

bind cpu_subsystem cpu_subsystem_asserts i_cpu_subsystem_asserts (
	.clk_6m(clk_6m),
	.rst_n(rst_n),
	.m_req(m_req),
	.m_ack(m_ack),
	.s_req(s_req),
	.s_ack(s_ack),
	.vid_bus(vid_bus),
	.m_grant(m_vid_grant)
);

`default_nettype wire

// ==== dv/cpu_subsystem_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_subsystem_tb;

	import cpu_subsystem_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int WAIT_LIMIT = 50;

	// Select bits with scroll0 as the MSB of vid_sel_t
	localparam vid_sel_t SEL_NONE = 6'b000000;
	localparam vid_sel_t SEL_SCROLL0 = 6'b100000;
	localparam vid_sel_t SEL_SCROLL1 = 6'b010000;
	localparam vid_sel_t SEL_OBJECT = 6'b001000;
	localparam vid_sel_t SEL_LATCH0 = 6'b000100;
	localparam vid_sel_t SEL_LATCH1 = 6'b000010;
	localparam vid_sel_t SEL_BACKCOLOR = 6'b000001;

	typedef struct packed {
		logic cpu;
		logic [15:0] addr;
		logic we;
		logic [7:0] wdata;
		logic [7:0] exp_rdata;
		vid_sel_t exp_sel;
	} entry_t;

	logic clk_6m = 1'b0;
	logic rst_n;
	logic vblank_n;
	logic m_req;
	logic s_req;
	cpu_req_t m_cpu;
	cpu_req_t s_cpu;
	logic [7:0] vid_rdata;
	logic m_ack;
	logic s_ack;
	logic [7:0] m_rdata;
	logic [7:0] s_rdata;
	logic m_irq_n;
	logic s_irq_n;
	vid_bus_t vid_bus;

	int value_errors = 0;
	int protocol_errors = 0;
	int checks = 0;
	int edge_cnt;
	logic [31:0] rnd_state;
	logic [7:0] rom_image [0:(1 << ROM_ADDR_W) - 1];
	entry_t stim_q[$];
	vid_bus_t bus_log[$];

	always #(CLK_PERIOD / 2) clk_6m = ~clk_6m;

	cpu_subsystem i_cpu_subsystem (
		.clk_6m(clk_6m),
		.rst_n(rst_n),
		.vblank_n(vblank_n),
		.m_req(m_req),
		.m_cpu(m_cpu),
		.s_req(s_req),
		.s_cpu(s_cpu),
		.vid_rdata(vid_rdata),
		.m_ack(m_ack),
		.m_rdata(m_rdata),
		.m_irq_n(m_irq_n),
		.s_ack(s_ack),
		.s_rdata(s_rdata),
		.s_irq_n(s_irq_n),
		.vid_bus(vid_bus)
	);

	////////////////////
	// Video memory model and monitor

	function automatic logic [7:0] vid_model(input logic [12:0] addr);
		return addr[7:0] ^ 8'h5A;
	endfunction

	assign vid_rdata = vid_model(vid_bus.addr);

	always @(negedge clk_6m) begin
		if (rst_n && vid_bus.sel != SEL_NONE) begin
			bus_log.push_back(vid_bus);
		end
	end

	// Slot follows the LSB of the edge count since reset release
	always @(posedge clk_6m) begin
		if (!rst_n) begin
			edge_cnt <= 0;
		end else begin
			edge_cnt <= edge_cnt + 1;
		end
	end

	////////////////////
	// Helpers

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] rom_word(input logic cpu, input logic [15:0] addr);
		int idx;
		idx = int'(addr[3:0]);
		if (cpu) begin
			idx = idx + 16;
		end
		return rom_image[idx];
	endfunction

	function automatic entry_t make_entry(input logic cpu, input logic [15:0] addr,
		input logic we, input logic [7:0] exp_rdata, input vid_sel_t exp_sel);
		entry_t e;
		rnd_state = next_random(rnd_state);
		e.cpu = cpu;
		e.addr = addr;
		e.we = we;
		e.wdata = rnd_state[7:0];
		e.exp_rdata = exp_rdata;
		e.exp_sel = exp_sel;
		return e;
	endfunction

	function automatic vid_bus_t expected_bus(input entry_t e);
		vid_bus_t b;
		b.addr = e.addr[12:0];
		b.wdata = e.wdata;
		b.we = e.we;
		b.sel = e.exp_sel;
		return b;
	endfunction

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %s: got 0x%02h, expected 0x%02h", name, got, exp);
		end
	endtask

	task automatic check_bus(input string name, input vid_bus_t got, input vid_bus_t exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %s: got 0x%07h, expected 0x%07h", name, got, exp);
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic wait_acks(input logic use_m, input logic use_s, input logic level,
		output logic ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
			@(negedge clk_6m);
			ok = (!use_m || m_ack == level) && (!use_s || s_ack == level);
		end
		if (!ok) begin
			protocol_errors++;
			$display("ERROR: ack did not go %s within %0d cycles (master %0b, sub %0b)",
				level ? "high" : "low", WAIT_LIMIT, use_m, use_s);
		end
	endtask

	task automatic drive_request(input entry_t e);
		cpu_req_t payload;
		payload.addr = e.addr;
		payload.wdata = e.wdata;
		payload.we = e.we;
		if (e.cpu) begin
			s_req <= 1'b1;
			s_cpu <= payload;
		end else begin
			m_req <= 1'b1;
			m_cpu <= payload;
		end
	endtask

	task automatic check_bus_log(input int start, input entry_t e);
		if (e.exp_sel == SEL_NONE) begin
			if (bus_log.size() != start) begin
				protocol_errors++;
				$display("ERROR: access at 0x%04h drove the video bus", e.addr);
			end
		end else if (bus_log.size() != start + 1) begin
			protocol_errors++;
			$display("ERROR: access at 0x%04h gave %0d bus cycles instead of one",
				e.addr, bus_log.size() - start);
		end else begin
			check_bus("vid_bus", bus_log[start], expected_bus(e));
		end
	endtask

	// One full four-phase handshake
	task automatic run_entry(input entry_t e);
		int start;
		logic ok;
		start = bus_log.size();
		@(posedge clk_6m);
		drive_request(e);
		wait_acks(!e.cpu, e.cpu, 1'b1, ok);
		if (ok && !e.we) begin
			check_byte(e.cpu ? "s_rdata" : "m_rdata", e.cpu ? s_rdata : m_rdata, e.exp_rdata);
		end
		@(posedge clk_6m);
		if (e.cpu) begin
			s_req <= 1'b0;
		end else begin
			m_req <= 1'b0;
		end
		wait_acks(!e.cpu, e.cpu, 1'b0, ok);
		check_bus_log(start, e);
	endtask

	// Both CPUs request on the same edge with the master slot next
	task automatic run_dual_video(input entry_t me, input entry_t se);
		int start;
		int n;
		logic ok;
		logic aligned;
		start = bus_log.size();
		aligned = 1'b0;
		for (n = 0; n < 4 && !aligned; n++) begin
			@(negedge clk_6m);
			aligned = (edge_cnt[0] == 1'b0);
		end
		if (!aligned) begin
			protocol_errors++;
			$display("ERROR: could not line up with the master slot");
		end
		@(posedge clk_6m);
		drive_request(me);
		drive_request(se);
		wait_acks(1'b1, 1'b1, 1'b1, ok);
		if (ok) begin
			check_byte("m_rdata", m_rdata, me.exp_rdata);
		end
		@(posedge clk_6m);
		m_req <= 1'b0;
		s_req <= 1'b0;
		wait_acks(1'b1, 1'b1, 1'b0, ok);
		if (bus_log.size() != start + 2) begin
			protocol_errors++;
			$display("ERROR: dual access gave %0d bus cycles instead of two",
				bus_log.size() - start);
		end else begin
			check_bus("vid_bus", bus_log[start], expected_bus(me));
			check_bus("vid_bus", bus_log[start + 1], expected_bus(se));
		end
	endtask

	// Returns on the first interrupt of either CPU
	task automatic wait_irq_low();
		int n;
		logic seen;
		seen = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !seen; n++) begin
			@(negedge clk_6m);
			seen = !m_irq_n || !s_irq_n;
		end
		if (!seen) begin
			protocol_errors++;
			$display("ERROR: vblank did not raise an interrupt within %0d cycles", WAIT_LIMIT);
		end
	endtask

	////////////////////
	// Stimulus table

	task automatic build_table();
		// Program ROM reads in each CPU half
		stim_q.push_back(make_entry(1'b0, 16'hC003, 1'b0, rom_word(1'b0, 16'hC003), SEL_NONE));
		stim_q.push_back(make_entry(1'b0, 16'hFFFF, 1'b0, rom_word(1'b0, 16'hFFFF), SEL_NONE));
		stim_q.push_back(make_entry(1'b1, 16'hC000, 1'b0, rom_word(1'b1, 16'hC000), SEL_NONE));
		stim_q.push_back(make_entry(1'b1, 16'hE00A, 1'b0, rom_word(1'b1, 16'hE00A), SEL_NONE));
		// Master video regions
		stim_q.push_back(make_entry(1'b0, 16'h0123, 1'b1, 8'h00, SEL_SCROLL0));
		stim_q.push_back(make_entry(1'b0, 16'h2456, 1'b0, vid_model(13'h0456), SEL_SCROLL1));
		stim_q.push_back(make_entry(1'b0, 16'h4A10, 1'b1, 8'h00, SEL_OBJECT));
		stim_q.push_back(make_entry(1'b0, 16'h8007, 1'b0, vid_model(13'h0007), SEL_LATCH0));
		stim_q.push_back(make_entry(1'b0, 16'h9001, 1'b1, 8'h00, SEL_LATCH1));
		stim_q.push_back(make_entry(1'b0, 16'hA010, 1'b0, vid_model(13'h0010), SEL_BACKCOLOR));
		// Sub video regions
		stim_q.push_back(make_entry(1'b1, 16'h0042, 1'b0, vid_model(13'h0042), SEL_OBJECT));
		stim_q.push_back(make_entry(1'b1, 16'h2100, 1'b1, 8'h00, SEL_SCROLL0));
		stim_q.push_back(make_entry(1'b1, 16'h5FFF, 1'b0, vid_model(13'h1FFF), SEL_SCROLL1));
		stim_q.push_back(make_entry(1'b1, 16'h8800, 1'b1, 8'h00, SEL_LATCH0));
		stim_q.push_back(make_entry(1'b1, 16'h9ABC, 1'b0, vid_model(13'h1ABC), SEL_LATCH1));
		// Unmapped space including the sub backcolor hole
		stim_q.push_back(make_entry(1'b1, 16'hA010, 1'b0, NONE_RDATA, SEL_NONE));
		stim_q.push_back(make_entry(1'b0, 16'h6000, 1'b0, NONE_RDATA, SEL_NONE));
		stim_q.push_back(make_entry(1'b0, 16'h7FFF, 1'b0, NONE_RDATA, SEL_NONE));
	endtask

	////////////////////
	// Main sequence

	initial begin
		vid_bus_t idle_bus;
		int assert_errors;
		rst_n = 1'b0;
		vblank_n = 1'b1;
		m_req = 1'b0;
		s_req = 1'b0;
		m_cpu = '0;
		s_cpu = '0;
		rnd_state = 32'd11847;
		$readmemh(ROM_FILE, rom_image);
		build_table();

		repeat (RESET_CYCLES) @(posedge clk_6m);
		rst_n <= 1'b1;
		@(negedge clk_6m);
		check_level("m_ack", m_ack, 1'b0);
		check_level("s_ack", s_ack, 1'b0);
		check_level("m_irq_n", m_irq_n, 1'b1);
		check_level("s_irq_n", s_irq_n, 1'b1);
		// Only sel and we are defined on an idle bus
		idle_bus = '0;
		idle_bus.sel = vid_bus.sel;
		idle_bus.we = vid_bus.we;
		check_bus("vid_bus", idle_bus, '0);

		foreach (stim_q[n]) begin
			run_entry(stim_q[n]);
		end

		run_dual_video(make_entry(1'b0, 16'h0FF0, 1'b0, vid_model(13'h0FF0), SEL_SCROLL0),
			make_entry(1'b1, 16'h1234, 1'b1, 8'h00, SEL_OBJECT));

		// Vblank interrupt and acknowledge one CPU at a time
		@(posedge clk_6m);
		vblank_n <= 1'b0;
		wait_irq_low();
		check_level("m_irq_n", m_irq_n, 1'b0);
		check_level("s_irq_n", s_irq_n, 1'b0);
		@(posedge clk_6m);
		vblank_n <= 1'b1;
		run_entry(make_entry(1'b0, 16'hB000, 1'b0, 8'h00, SEL_NONE));
		check_level("m_irq_n", m_irq_n, 1'b1);
		check_level("s_irq_n", s_irq_n, 1'b0);
		run_entry(make_entry(1'b1, 16'hB004, 1'b0, 8'h00, SEL_NONE));
		check_level("m_irq_n", m_irq_n, 1'b1);
		check_level("s_irq_n", s_irq_n, 1'b1);

		repeat (2) @(posedge clk_6m);
		assert_errors = int'(i_cpu_subsystem.i_cpu_subsystem_asserts.fail_total);
		$display("Errors: value %0d, protocol %0d, assertion %0d in %0d checks",
			value_errors, protocol_errors, assert_errors, checks);
		if (value_errors == 0 && protocol_errors == 0 && assert_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/cpu_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_port (
	input wire logic clk_6m,
	input wire logic rst_n,
	input wire logic req,
	input wire cpu_subsystem_pkg::cpu_req_t cpu,
	input wire cpu_subsystem_pkg::region_e region,
	input wire logic [7:0] rom_data,
	input wire logic vid_grant,
	input wire logic [7:0] vid_rdata_q,
	output logic ack,
	output logic [7:0] rdata,
	output logic done,
	output logic [cpu_subsystem_pkg::ROM_ADDR_W-2:0] rom_idx,
	output logic vid_pend,
	output cpu_subsystem_pkg::vid_access_t vid_acc
);

	import cpu_subsystem_pkg::*;

	// ROM also covers the one-cycle local replies
	typedef enum logic [1:0] {IDLE, ROM, VIDEO, ACKED} state_e;

	state_e state;
	region_e cur_region;
	logic rom_wait;
	logic is_video;
	logic finish;
	logic [7:0] reply_data;

	always_comb begin
		is_video = region inside {REG_SCROLL0, REG_SCROLL1, REG_OBJECT,
			REG_LATCH0, REG_LATCH1, REG_BACKCOLOR};
		finish = 1'b0;
		reply_data = vid_rdata_q;
		if (state == ROM && !rom_wait) begin
			finish = 1'b1;
			case (cur_region)
				REG_PROG_ROM: reply_data = rom_data;
				REG_IRQ_ACK: reply_data = 8'h00;
				default: reply_data = NONE_RDATA;
			endcase
		end else if (state == VIDEO && vid_grant) begin
			finish = 1'b1;
		end
	end

	////////////////////
	// Handshake FSM

	always_ff @(posedge clk_6m) begin
		if (!rst_n) begin
			state <= IDLE;
			ack <= 1'b0;
			done <= 1'b0;
			vid_pend <= 1'b0;
			rom_wait <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					if (req) begin
						if (is_video) begin
							state <= VIDEO;
							vid_pend <= 1'b1;
						end else begin
							state <= ROM;
							// Extra cycle for the registered ROM read
							rom_wait <= (region == REG_PROG_ROM);
						end
					end
				end
				ROM: begin
					rom_wait <= 1'b0;
				end
				ACKED: begin
					if (!req) begin
						ack <= 1'b0;
						state <= IDLE;
					end
				end
				default: ;
			endcase
			if (finish) begin
				ack <= 1'b1;
				done <= 1'b1;
				vid_pend <= 1'b0;
				state <= ACKED;
			end
		end
	end

	// Request payload and read data
	always_ff @(posedge clk_6m) begin
		if (state == IDLE && req) begin
			cur_region <= region;
			rom_idx <= cpu.addr[ROM_ADDR_W-2:0];
			vid_acc.addr <= cpu.addr[12:0];
			vid_acc.wdata <= cpu.wdata;
			vid_acc.we <= cpu.we;
			vid_acc.region <= region;
		end
		if (finish) begin
			rdata <= reply_data;
		end
	end

endmodule

`default_nettype wire

// ==== source/cpu_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_subsystem (
	input wire logic clk_6m,
	input wire logic rst_n,
	input wire logic vblank_n,
	input wire logic m_req,
	input wire cpu_subsystem_pkg::cpu_req_t m_cpu,
	input wire logic s_req,
	input wire cpu_subsystem_pkg::cpu_req_t s_cpu,
	input wire logic [7:0] vid_rdata,
	output logic m_ack,
	output logic [7:0] m_rdata,
	output logic m_irq_n,
	output logic s_ack,
	output logic [7:0] s_rdata,
	output logic s_irq_n,
	output cpu_subsystem_pkg::vid_bus_t vid_bus
);

	import cpu_subsystem_pkg::*;

	region_e m_region;
	region_e s_region;
	logic m_done;
	logic s_done;
	logic [ROM_ADDR_W-2:0] m_rom_idx;
	logic [ROM_ADDR_W-2:0] s_rom_idx;
	logic [7:0] m_rom_data;
	logic [7:0] s_rom_data;
	logic m_vid_pend;
	logic s_vid_pend;
	vid_access_t m_vid_acc;
	vid_access_t s_vid_acc;
	logic m_vid_grant;
	logic s_vid_grant;
	logic [7:0] vid_rdata_q;

	////////////////////
	// Master CPU side

	master_decoder i_master_decoder (
		.clk_6m(clk_6m),
		.rst_n(rst_n),
		.addr(m_cpu.addr),
		.vblank_n(vblank_n),
		.done(m_done),
		.region(m_region),
		.irq_n(m_irq_n)
	);

	cpu_port i_master_port (
		.clk_6m(clk_6m),
		.rst_n(rst_n),
		.req(m_req),
		.cpu(m_cpu),
		.region(m_region),
		.rom_data(m_rom_data),
		.vid_grant(m_vid_grant),
		.vid_rdata_q(vid_rdata_q),
		.ack(m_ack),
		.rdata(m_rdata),
		.done(m_done),
		.rom_idx(m_rom_idx),
		.vid_pend(m_vid_pend),
		.vid_acc(m_vid_acc)
	);

	////////////////////
	// Sub CPU side

	sub_decoder i_sub_decoder (
		.clk_6m(clk_6m),
		.rst_n(rst_n),
		.addr(s_cpu.addr),
		.vblank_n(vblank_n),
		.done(s_done),
		.region(s_region),
		.irq_n(s_irq_n)
	);

	cpu_port i_sub_port (
		.clk_6m(clk_6m),
		.rst_n(rst_n),
		.req(s_req),
		.cpu(s_cpu),
		.region(s_region),
		.rom_data(s_rom_data),
		.vid_grant(s_vid_grant),
		.vid_rdata_q(vid_rdata_q),
		.ack(s_ack),
		.rdata(s_rdata),
		.done(s_done),
		.rom_idx(s_rom_idx),
		.vid_pend(s_vid_pend),
		.vid_acc(s_vid_acc)
	);

	////////////////////
	// Shared resources

	video_bus_mux i_video_bus_mux (
		.clk_6m(clk_6m),
		.rst_n(rst_n),
		.m_pend(m_vid_pend),
		.m_acc(m_vid_acc),
		.s_pend(s_vid_pend),
		.s_acc(s_vid_acc),
		.vid_rdata(vid_rdata),
		.vid_bus(vid_bus),
		.m_grant(m_vid_grant),
		.s_grant(s_vid_grant),
		.vid_rdata_q(vid_rdata_q)
	);

	program_rom i_program_rom (
		.clk_6m(clk_6m),
		.m_idx(m_rom_idx),
		.s_idx(s_rom_idx),
		.m_data(m_rom_data),
		.s_data(s_rom_data)
	);

endmodule

`default_nettype wire

// ==== source/cpu_subsystem_pkg.sv ====
`default_nettype none

package cpu_subsystem_pkg;

	////////////////////
	// Program ROM

	// Word index; each CPU sees 16 words through addr[3:0]
	localparam int ROM_ADDR_W = 5;
	localparam string ROM_FILE = "source/program_rom.hex";

	// Read value for unmapped space
	localparam logic [7:0] NONE_RDATA = 8'hFF;

	////////////////////
	// Address map bases

	// Master map
	localparam logic [15:0] M_SCROLL0_BASE = 16'h0000;
	localparam logic [15:0] M_SCROLL1_BASE = 16'h2000;
	localparam logic [15:0] M_OBJECT_BASE = 16'h4000;
	localparam logic [15:0] M_BACKCOLOR_BASE = 16'hA000;

	// Sub map, object RAM at the bottom
	localparam logic [15:0] S_OBJECT_BASE = 16'h0000;
	localparam logic [15:0] S_SCROLL0_BASE = 16'h2000;
	localparam logic [15:0] S_SCROLL1_BASE = 16'h4000;
	localparam logic [15:0] S_UNUSED_BASE = 16'hA000;

	// Common to both maps
	localparam logic [15:0] VRAM_END = 16'h6000;
	localparam logic [15:0] LATCH0_BASE = 16'h8000;
	localparam logic [15:0] LATCH1_BASE = 16'h9000;
	localparam logic [15:0] IRQ_ACK_BASE = 16'hB000;
	localparam logic [15:0] PROG_ROM_BASE = 16'hC000;

	////////////////////
	// Types

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0] wdata;
		logic we;
	} cpu_req_t;

	// Nine targets, so four bits
	typedef enum logic [3:0] {
		REG_NONE,
		REG_PROG_ROM,
		REG_SCROLL0,
		REG_SCROLL1,
		REG_OBJECT,
		REG_LATCH0,
		REG_LATCH1,
		REG_BACKCOLOR,
		REG_IRQ_ACK
	} region_e;

	typedef struct packed {
		logic scroll0;
		logic scroll1;
		logic object;
		logic latch0;
		logic latch1;
		logic backcolor;
	} vid_sel_t;

	typedef struct packed {
		logic [12:0] addr;
		logic [7:0] wdata;
		logic we;
		region_e region;
	} vid_access_t;

	typedef struct packed {
		logic [12:0] addr;
		logic [7:0] wdata;
		logic we;
		vid_sel_t sel;
	} vid_bus_t;

	// True when base <= addr < limit
	function automatic logic in_range(input logic [15:0] addr, input logic [15:0] base,
		input logic [15:0] limit);
		return (addr >= base) && (addr < limit);
	endfunction

endpackage

`default_nettype wire

// ==== source/master_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module master_decoder (
	input wire logic clk_6m,
	input wire logic rst_n,
	input wire logic [15:0] addr,
	input wire logic vblank_n,
	input wire logic done,
	output cpu_subsystem_pkg::region_e region,
	output logic irq_n
);

	import cpu_subsystem_pkg::*;

	logic vblank_q;
	logic vblank_fall;
	logic irq_flag;

	////////////////////
	// Address map

	always_comb begin
		if (addr >= PROG_ROM_BASE) begin
			region = REG_PROG_ROM;
		end else if (in_range(addr, IRQ_ACK_BASE, PROG_ROM_BASE)) begin
			region = REG_IRQ_ACK;
		end else if (in_range(addr, M_BACKCOLOR_BASE, IRQ_ACK_BASE)) begin
			region = REG_BACKCOLOR;
		end else if (in_range(addr, LATCH1_BASE, M_BACKCOLOR_BASE)) begin
			region = REG_LATCH1;
		end else if (in_range(addr, LATCH0_BASE, LATCH1_BASE)) begin
			region = REG_LATCH0;
		end else if (in_range(addr, M_OBJECT_BASE, VRAM_END)) begin
			region = REG_OBJECT;
		end else if (in_range(addr, M_SCROLL1_BASE, M_OBJECT_BASE)) begin
			region = REG_SCROLL1;
		end else if (in_range(addr, M_SCROLL0_BASE, M_SCROLL1_BASE)) begin
			region = REG_SCROLL0;
		end else begin
			region = REG_NONE;
		end
	end

	////////////////////
	// Vblank interrupt

	assign vblank_fall = vblank_q & ~vblank_n;

	always_ff @(posedge clk_6m) begin
		if (!rst_n) begin
			vblank_q <= 1'b1;
			irq_flag <= 1'b0;
		end else begin
			vblank_q <= vblank_n;
			// Set takes priority over the acknowledge
			if (vblank_fall) begin
				irq_flag <= 1'b1;
			end else if (done && region == REG_IRQ_ACK) begin
				irq_flag <= 1'b0;
			end
		end
	end

	assign irq_n = ~irq_flag;

endmodule

`default_nettype wire

// ==== source/program_rom.hex ====
// One byte per line, hex
// Words 0-15 are the master half, words 16-31 the sub half
3C
8E
01
F7
52
A9
6D
10
C4
2B
E3
77
98
05
BE
4F
D1
66
1A
83
F0
2E
B5
49
0C
7A
E8
35
9F
C2
58
A4

// ==== source/program_rom.sv ====
`timescale 1ns/10ps
`default_nettype none

module program_rom (
	input wire logic clk_6m,
	input wire logic [cpu_subsystem_pkg::ROM_ADDR_W-2:0] m_idx,
	input wire logic [cpu_subsystem_pkg::ROM_ADDR_W-2:0] s_idx,
	output logic [7:0] m_data,
	output logic [7:0] s_data
);

	import cpu_subsystem_pkg::*;

	// Lower half master, upper half sub
	logic [7:0] mem [0:(1 << ROM_ADDR_W) - 1];

	initial begin
		$readmemh(ROM_FILE, mem);
	end

	// One registered read per CPU
	always_ff @(posedge clk_6m) begin
		m_data <= mem[{1'b0, m_idx}];
		s_data <= mem[{1'b1, s_idx}];
	end

endmodule

`default_nettype wire

// ==== source/sub_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module sub_decoder (
	input wire logic clk_6m,
	input wire logic rst_n,
	input wire logic [15:0] addr,
	input wire logic vblank_n,
	input wire logic done,
	output cpu_subsystem_pkg::region_e region,
	output logic irq_n
);

	import cpu_subsystem_pkg::*;

	logic vblank_q;
	logic vblank_fall;
	logic irq_flag;

	// Sub map, no backcolor latch here
	always_comb begin
		if (addr >= PROG_ROM_BASE) begin
			region = REG_PROG_ROM;
		end else if (in_range(addr, IRQ_ACK_BASE, PROG_ROM_BASE)) begin
			region = REG_IRQ_ACK;
		end else if (in_range(addr, LATCH1_BASE, S_UNUSED_BASE)) begin
			region = REG_LATCH1;
		end else if (in_range(addr, LATCH0_BASE, LATCH1_BASE)) begin
			region = REG_LATCH0;
		end else if (in_range(addr, S_SCROLL1_BASE, VRAM_END)) begin
			region = REG_SCROLL1;
		end else if (in_range(addr, S_SCROLL0_BASE, S_SCROLL1_BASE)) begin
			region = REG_SCROLL0;
		end else if (in_range(addr, S_OBJECT_BASE, S_SCROLL0_BASE)) begin
			region = REG_OBJECT;
		end else begin
			region = REG_NONE;
		end
	end

	// Falling edge of vblank_n
	assign vblank_fall = vblank_q & ~vblank_n;

	always_ff @(posedge clk_6m) begin
		if (!rst_n) begin
			vblank_q <= 1'b1;
			irq_flag <= 1'b0;
		end else begin
			vblank_q <= vblank_n;
			if (vblank_fall) begin
				irq_flag <= 1'b1;
			end else if (done && region == REG_IRQ_ACK) begin
				irq_flag <= 1'b0;
			end
		end
	end

	assign irq_n = ~irq_flag;

endmodule

`default_nettype wire

// ==== source/video_bus_mux.sv ====
`timescale 1ns/10ps
`default_nettype none

module video_bus_mux (
	input wire logic clk_6m,
	input wire logic rst_n,
	input wire logic m_pend,
	input wire cpu_subsystem_pkg::vid_access_t m_acc,
	input wire logic s_pend,
	input wire cpu_subsystem_pkg::vid_access_t s_acc,
	input wire logic [7:0] vid_rdata,
	output cpu_subsystem_pkg::vid_bus_t vid_bus,
	output logic m_grant,
	output logic s_grant,
	output logic [7:0] vid_rdata_q
);

	import cpu_subsystem_pkg::*;

	// 0 for master, 1 for sub, like 2H on the board
	logic slot;
	logic owner_pend;
	vid_access_t owner_acc;

	function automatic vid_sel_t region_sel(input region_e r);
		vid_sel_t s;
		s = '0;
		case (r)
			REG_SCROLL0: s.scroll0 = 1'b1;
			REG_SCROLL1: s.scroll1 = 1'b1;
			REG_OBJECT: s.object = 1'b1;
			REG_LATCH0: s.latch0 = 1'b1;
			REG_LATCH1: s.latch1 = 1'b1;
			REG_BACKCOLOR: s.backcolor = 1'b1;
			default: s = '0;
		endcase
		return s;
	endfunction

	////////////////////
	// Slot owner

	always_comb begin
		owner_pend = slot ? s_pend : m_pend;
		owner_acc = slot ? s_acc : m_acc;
	end

	// Bus stays idle unless the slot owner has something queued
	always_comb begin
		vid_bus = '0;
		if (owner_pend) begin
			vid_bus.addr = owner_acc.addr;
			vid_bus.wdata = owner_acc.wdata;
			vid_bus.we = owner_acc.we;
			vid_bus.sel = region_sel(owner_acc.region);
		end
	end

	////////////////////
	// Slot and grants

	always_ff @(posedge clk_6m) begin
		if (!rst_n) begin
			slot <= 1'b0;
			m_grant <= 1'b0;
			s_grant <= 1'b0;
		end else begin
			slot <= ~slot;
			m_grant <= owner_pend & ~slot;
			s_grant <= owner_pend & slot;
		end
	end

	// Memory answers within the bus cycle
	always_ff @(posedge clk_6m) begin
		if (owner_pend) begin
			vid_rdata_q <= vid_rdata;
		end
	end

endmodule

`default_nettype wire
